// ==== flist.f ====
+incdir+sim
hw/frame_pkg.sv
hw/csr_pkg.sv
hw/buf_rd_if.sv
hw/sync_fifo.sv
hw/frame_seq_fsm.sv
hw/eth_framer.sv
hw/readout_csr.sv
hw/readout_top.sv
sim/tb_readout.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
TOP ?= tb_readout
FLIST ?= flist.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_tasks.svh ====
// Wishbone classic write, ack looked for at mid-cycle
task automatic wb_write(input logic [csr_pkg::WB_AW-1:0] adr, input logic [31:0] data);
	int n;
	n = 0;
	@(posedge RCLK);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b1;
	wb_adr <= adr;
	wb_dat_w <= data;
	@(negedge RCLK);
	while (!wb_ack && n < 8) begin
		@(negedge RCLK);
		n++;
	end
	checks++;
	if (!wb_ack) begin
		errors++;
		$display("no ack for the write to address %0d at time %0t", adr, $time);
	end
	@(posedge RCLK);   // write lands on this edge
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
	wb_we <= 1'b0;
endtask

task automatic wb_read(input logic [csr_pkg::WB_AW-1:0] adr, output logic [31:0] data);
	int n;
	n = 0;
	data = '0;
	@(posedge RCLK);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b0;
	wb_adr <= adr;
	@(negedge RCLK);
	while (!wb_ack && n < 8) begin
		@(negedge RCLK);
		n++;
	end
	checks++;
	if (!wb_ack) begin
		errors++;
		$display("no ack for the read of address %0d at time %0t", adr, $time);
	end else begin
		data = wb_dat_r;
	end
	@(posedge RCLK);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
endtask

task automatic read_expect(input logic [csr_pkg::WB_AW-1:0] adr, input logic [31:0] want,
	input string tag);
	logic [31:0] data;
	wb_read(adr, data);
	checks++;
	if (data !== want) begin
		errors++;
		$display("** Error @ %0t: %s read %h, expected %h", $time, tag, data, want);
	end
endtask

function automatic logic [31:0] ctrl_value(input int smax, input logic warn_bit,
	input logic en);
	logic [31:0] v;
	v = '0;
	v[6:0] = 7'(smax);
	v[8] = warn_bit;
	v[16] = en;
	return v;
endfunction

task automatic push_samples(input int n);
	logic [17:0] s;
	int i;
	for (i = 0; i < n; i++) begin
		s = 18'($urandom);   // upper bits random too, framer ignores them
		samp_q.push_back(s);
		@(posedge RCLK);
		wdata <= s;
		wren <= 1'b1;
	end
	@(posedge RCLK);
	wren <= 1'b0;
endtask

task automatic push_trigger(input logic phase, output logic [36:0] rec);
	rec = {phase, 12'($urandom), 24'($urandom)};
	@(posedge RCLK);
	l1a_evt_data <= rec;
	l1a_wrt_en <= 1'b1;
	@(posedge RCLK);
	l1a_wrt_en <= 1'b0;
endtask

// gathers n accepted words, txack random when toggle is set
task automatic collect_frame(input int n, input logic toggle);
	int cyc;
	int limit;
	logic held;
	logic [15:0] held_word;
	cyc = 0;
	limit = n * 20 + 100;
	held = 1'b0;
	held_word = '0;
	while (got_q.size() < n && cyc < limit) begin
		@(posedge RCLK);
		txack <= toggle ? 1'($urandom % 2) : 1'b1;
		@(negedge RCLK);
		cyc++;
		if (held && (!txd_vld || txd !== held_word)) begin
			errors++;
			$display("** Error @ %0t: word %h not held during stall", $time, held_word);
		end
		if (got_q.size() > 0 && !txd_vld) begin
			errors++;
			$display("** Error @ %0t: txd_vld low after word %0d of the frame",
				$time, got_q.size());
		end
		if (txd_vld && txack)
			got_q.push_back(txd);   // taken on the next edge
		held = txd_vld & ~txack;
		held_word = txd;
	end
	if (got_q.size() < n) begin
		errors++;
		$display("frame incomplete after %0d cycles, %0d of %0d words arrived",
			cyc, got_q.size(), n);
	end
	@(posedge RCLK);
	txack <= 1'b0;
endtask

task automatic expect_idle(input int cycles, input string tag);
	logic seen;
	int i;
	seen = 1'b0;
	for (i = 0; i < cycles && !seen; i++) begin
		@(negedge RCLK);
		seen = txd_vld;
	end
	checks++;
	if (seen) begin
		errors++;
		$display("** Error @ %0t: txd_vld high while %s", $time, tag);
	end
endtask

task automatic csr_roundtrip;
	read_expect(csr_pkg::ADDR_STAT, 32'h0, "STAT after reset");
	read_expect(csr_pkg::ADDR_CTRL, 32'h0, "CTRL after reset");
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(15, 1'b1, 1'b0));
	read_expect(csr_pkg::ADDR_CTRL, 32'h0000_010F, "CTRL readback");
endtask

task automatic single_frame;
	logic [36:0] rec;
	push_trigger(1'b1, rec);
	push_samples(16);
	model_frame(rec, 15, 1'b1, 0);
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(15, 1'b1, 1'b1));
	collect_frame(22, 1'b0);
	compare_frame(22, "single");
endtask

task automatic backpressure_frame;
	logic [36:0] rec;
	push_trigger(1'b0, rec);
	push_samples(16);   // frame starts here but stalls on txack
	model_frame(rec, 15, 1'b1, 0);
	collect_frame(22, 1'b1);
	compare_frame(22, "backpressure");
endtask

task automatic queued_frames;
	logic [36:0] rec [3];
	int i;
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(7, 1'b0, 1'b0));
	for (i = 0; i < 3; i++)
		push_trigger(1'b1, rec[i]);
	push_samples(24);
	read_expect(csr_pkg::ADDR_STAT, 32'h0000_1803, "STAT with three events queued");
	for (i = 0; i < 3; i++)
		model_frame(rec[i], 7, 1'b0, 2 - i);
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(7, 1'b0, 1'b1));
	for (i = 0; i < 3; i++) begin
		collect_frame(14, 1'b0);
		compare_frame(14, "queued");
	end
endtask

task automatic start_gating;
	logic [36:0] rec;
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(3, 1'b0, 1'b0));
	push_trigger(1'b0, rec);
	push_samples(3);
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(3, 1'b0, 1'b1));
	expect_idle(40, "only 3 of 4 samples buffered");
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(3, 1'b0, 1'b0));
	push_samples(1);
	expect_idle(40, "enable is low");
	model_frame(rec, 3, 1'b0, 0);
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(3, 1'b0, 1'b1));
	collect_frame(10, 1'b0);
	compare_frame(10, "gated");
endtask

task automatic overflow_sticky;
	wb_write(csr_pkg::ADDR_CTRL, ctrl_value(3, 1'b0, 1'b0));
	push_samples(258);   // two past the depth
	samp_q.delete();
	read_expect(csr_pkg::ADDR_STAT, 32'h0101_0000, "STAT after overflow");
	wb_write(csr_pkg::ADDR_STAT, 32'h0100_0000);
	read_expect(csr_pkg::ADDR_STAT, 32'h0001_0000, "STAT after sticky clear");
endtask

// ==== sim/tb_readout.sv ====
`timescale 1ns/10ps

module tb_readout;

	localparam logic [31:0] SEED = 32'h67e797ec;
	// words of all frames in the run, 22 + 22 + 3*14 + 10
	localparam int FRAME_WORDS = 96;
	localparam int WATCHDOG_CYC = FRAME_WORDS * 20 + 2000;

	logic RCLK;
	logic RST_RESYNC;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [csr_pkg::WB_AW-1:0] wb_adr;
	logic [csr_pkg::WB_DW-1:0] wb_dat_w;
	logic [csr_pkg::WB_DW-1:0] wb_dat_r;
	logic wb_ack;
	logic [frame_pkg::EVT_W-1:0] wdata;
	logic wren;
	logic [frame_pkg::L1A_W-1:0] l1a_evt_data;
	logic l1a_wrt_en;
	logic [frame_pkg::TXD_W-1:0] txd;
	logic txd_vld;
	logic txack;

	int errors;
	int checks;
	logic [17:0] samp_q[$];   // pushed samples not framed yet
	logic [15:0] exp_q[$];
	logic [15:0] got_q[$];

	readout_top uut (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wdata(wdata),
		.wren(wren),
		.l1a_evt_data(l1a_evt_data),
		.l1a_wrt_en(l1a_wrt_en),
		.txd(txd),
		.txd_vld(txd_vld),
		.txack(txack)
	);

	always #5 RCLK = ~RCLK;

	// expected words for one record and the next N samples of samp_q
	function automatic void model_frame(input logic [36:0] rec, input int smax,
		input logic warn_bit, input int occ);
		logic [14:0] crc;
		logic [17:0] s;
		logic serial;
		logic [23:0] num;
		int k;
		num = rec[23:0];
		crc = '0;
		exp_q.push_back({4'h0, num[23:12]});
		exp_q.push_back({4'h0, num[11:0]});
		for (k = 0; k <= smax; k++) begin
			s = samp_q.pop_front();
			if (k <= 5)
				serial = rec[36];   // phase window
			else if (k <= 11)
				serial = (smax == 15);
			else
				serial = 1'b0;
			exp_q.push_back({2'b01, serial, 1'b0, s[11:0]});
			crc = frame_pkg::crc15_d13({1'b0, s[11:0]}, crc);
		end
		exp_q.push_back({1'b0, crc});
		exp_q.push_back(16'h700C);
		exp_q.push_back({4'h7, num[5:0], 5'(occ), warn_bit});
		exp_q.push_back(16'h7FFF);
	endfunction

	task automatic compare_frame(input int n, input string tag);
		logic [15:0] want;
		int i;
		checks++;
		if (got_q.size() != n) begin
			errors++;
			$display("** Error @ %0t: %s frame has %0d words, expected %0d",
				$time, tag, got_q.size(), n);
		end
		for (i = 0; i < n; i++) begin
			want = exp_q.pop_front();
			if (i < got_q.size()) begin
				checks++;
				if (got_q[i] !== want) begin
					errors++;
					$display("** Error @ %0t: %s word %0d is %h, expected %h",
						$time, tag, i, got_q[i], want);
				end
			end
		end
		got_q.delete();
	endtask

	`include "tb_tasks.svh"

	initial begin
		RCLK = 1'b0;
		RST_RESYNC = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wdata = '0;
		wren = 1'b0;
		l1a_evt_data = '0;
		l1a_wrt_en = 1'b0;
		txack = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(SEED));
		repeat (3) @(posedge RCLK);
		RST_RESYNC <= 1'b0;
		@(posedge RCLK);

		csr_roundtrip();
		single_frame();
		backpressure_frame();
		queued_frames();
		start_gating();
		overflow_sticky();   // leaves the event buffer full, so it runs last

		repeat (5) @(posedge RCLK);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge RCLK);
		$display("watchdog expired after %0d cycles, the test sequence did not finish",
			WATCHDOG_CYC);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== hw/readout_top.sv ====
`timescale 1ns/10ps

module readout_top (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [csr_pkg::WB_AW-1:0] wb_adr,
	input logic [csr_pkg::WB_DW-1:0] wb_dat_w,
	output logic [csr_pkg::WB_DW-1:0] wb_dat_r,
	output logic wb_ack,
	input logic [frame_pkg::EVT_W-1:0] wdata,
	input logic wren,
	input logic [frame_pkg::L1A_W-1:0] l1a_evt_data,
	input logic l1a_wrt_en,
	output logic [frame_pkg::TXD_W-1:0] txd,
	output logic txd_vld,
	input logic txack
);
	logic [frame_pkg::SMAX_W-1:0] samp_max;
	logic warn;
	logic enable;
	logic [frame_pkg::EVT_DEPTH_LOG2:0] evt_count;
	logic [frame_pkg::L1A_DEPTH_LOG2:0] l1a_count;
	logic evt_ovf;
	logic l1a_ovf;

	readout_csr csr (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.samp_max(samp_max),
		.warn(warn),
		.enable(enable),
		.evt_count(evt_count),
		.l1a_count(l1a_count),
		.evt_ovf(evt_ovf),
		.l1a_ovf(l1a_ovf)
	);

	eth_framer framer (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.wdata(wdata),
		.wren(wren),
		.l1a_evt_data(l1a_evt_data),
		.l1a_wrt_en(l1a_wrt_en),
		.samp_max(samp_max),
		.warn(warn),
		.enable(enable),
		.txack(txack),
		.txd(txd),
		.txd_vld(txd_vld),
		.evt_count(evt_count),
		.l1a_count(l1a_count),
		.evt_ovf(evt_ovf),
		.l1a_ovf(l1a_ovf)
	);

endmodule

// ==== hw/readout_csr.sv ====
`timescale 1ns/10ps

module readout_csr (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [csr_pkg::WB_AW-1:0] wb_adr,
	input logic [csr_pkg::WB_DW-1:0] wb_dat_w,
	output logic [csr_pkg::WB_DW-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [csr_pkg::CTRL_SMAX_W-1:0] samp_max,
	output logic warn,
	output logic enable,
	input logic [csr_pkg::STAT_EVT_W-1:0] evt_count,
	input logic [csr_pkg::STAT_L1A_W-1:0] l1a_count,
	input logic evt_ovf,
	input logic l1a_ovf
);
	logic acc_wr;
	logic ctrl_wr;
	logic stat_wr;
	logic evt_sticky;
	logic l1a_sticky;
	logic [csr_pkg::WB_DW-1:0] ctrl_word;
	logic [csr_pkg::WB_DW-1:0] stat_word;

	// write lands at the end of the ack cycle
	assign acc_wr = wb_cyc & wb_stb & wb_we & wb_ack;
	assign ctrl_wr = acc_wr & (wb_adr == csr_pkg::ADDR_CTRL);
	assign stat_wr = acc_wr & (wb_adr == csr_pkg::ADDR_STAT);

	always_comb begin
		ctrl_word = '0;
		ctrl_word[csr_pkg::CTRL_SMAX_LSB +: csr_pkg::CTRL_SMAX_W] = samp_max;
		ctrl_word[csr_pkg::CTRL_WARN] = warn;
		ctrl_word[csr_pkg::CTRL_EN] = enable;

		stat_word = '0;
		stat_word[csr_pkg::STAT_L1A_LSB +: csr_pkg::STAT_L1A_W] = l1a_count;
		stat_word[csr_pkg::STAT_EVT_LSB +: csr_pkg::STAT_EVT_W] = evt_count;
		stat_word[csr_pkg::STAT_EVT_OVF] = evt_sticky;
		stat_word[csr_pkg::STAT_L1A_OVF] = l1a_sticky;

		if (wb_adr == csr_pkg::ADDR_CTRL)
			wb_dat_r = ctrl_word;
		else if (wb_adr == csr_pkg::ADDR_STAT)
			wb_dat_r = stat_word;
		else
			wb_dat_r = '0;   // unmapped
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wb_ack <= 1'b0;
			samp_max <= '0;
			warn <= 1'b0;
			enable <= 1'b0;
			evt_sticky <= 1'b0;
			l1a_sticky <= 1'b0;
		end else begin
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;   // one ack per access
			if (ctrl_wr) begin
				samp_max <= wb_dat_w[csr_pkg::CTRL_SMAX_LSB +: csr_pkg::CTRL_SMAX_W];
				warn <= wb_dat_w[csr_pkg::CTRL_WARN];
				enable <= wb_dat_w[csr_pkg::CTRL_EN];
			end
			// new overflow wins over a clear in the same cycle
			evt_sticky <= evt_ovf |
				(evt_sticky & ~(stat_wr & wb_dat_w[csr_pkg::STAT_EVT_OVF]));
			l1a_sticky <= l1a_ovf |
				(l1a_sticky & ~(stat_wr & wb_dat_w[csr_pkg::STAT_L1A_OVF]));
		end
	end

endmodule

// ==== hw/eth_framer.sv ====
`timescale 1ns/10ps

module eth_framer (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic [frame_pkg::EVT_W-1:0] wdata,
	input logic wren,
	input logic [frame_pkg::L1A_W-1:0] l1a_evt_data,
	input logic l1a_wrt_en,
	input logic [frame_pkg::SMAX_W-1:0] samp_max,
	input logic warn,
	input logic enable,
	input logic txack,
	output logic [frame_pkg::TXD_W-1:0] txd,
	output logic txd_vld,
	output logic [frame_pkg::EVT_DEPTH_LOG2:0] evt_count,
	output logic [frame_pkg::L1A_DEPTH_LOG2:0] l1a_count,
	output logic evt_ovf,
	output logic l1a_ovf
);
	buf_rd_if #(.W(frame_pkg::EVT_W), .DEPTH_LOG2(frame_pkg::EVT_DEPTH_LOG2)) ev_rd ();
	buf_rd_if #(.W(frame_pkg::L1A_W), .DEPTH_LOG2(frame_pkg::L1A_DEPTH_LOG2)) l1a_rd ();

	logic go;
	logic [frame_pkg::EVT_DEPTH_LOG2:0] need;
	logic [frame_pkg::SMAX_W-1:0] samp_max_r;
	logic warn_r;
	logic pop_l1a;
	logic pop_evt;
	logic clr_crc;
	logic adv;
	logic last;
	logic [frame_pkg::POS_W-1:0] pos;
	logic [1:0] phase_sel;
	logic [frame_pkg::L1A_NUM_W-1:0] hdr_num;
	logic [frame_pkg::L1A_NUM_W-1:0] num_r;
	logic phase_r;
	logic pop_l1a_d;
	logic [frame_pkg::OCC_W-1:0] occ_r;
	logic [frame_pkg::CRC_W-1:0] crc_r;
	logic [frame_pkg::SAMP_W-1:0] samp;
	logic serial;
	logic [frame_pkg::TXD_W-1:0] word;
	logic [frame_pkg::TXD_W-1:0] asm_word;
	logic asm_vld;
	logic out_ready;

	sync_fifo #(.W(frame_pkg::EVT_W), .DEPTH_LOG2(frame_pkg::EVT_DEPTH_LOG2)) evt_buf (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.flush(1'b0),
		.din(wdata),
		.wr(wren),
		.rd_port(ev_rd.buffer),
		.overflow(evt_ovf)
	);

	sync_fifo #(.W(frame_pkg::L1A_W), .DEPTH_LOG2(frame_pkg::L1A_DEPTH_LOG2)) l1a_buf (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.flush(1'b0),
		.din(l1a_evt_data),
		.wr(l1a_wrt_en),
		.rd_port(l1a_rd.buffer),
		.overflow(l1a_ovf)
	);

	assign ev_rd.rd = pop_evt;
	assign l1a_rd.rd = pop_l1a;
	assign evt_count = ev_rd.count;
	assign l1a_count = l1a_rd.count;

	// whole event must be buffered before a frame starts
	assign need = {{(frame_pkg::EVT_DEPTH_LOG2+1-frame_pkg::SMAX_W){1'b0}}, samp_max} + 1'b1;
	assign go = enable & ~l1a_rd.empty & (ev_rd.count >= need);

	assign out_ready = ~txd_vld | txack;

	frame_seq_fsm seq (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.go(go),
		.samp_max_r(samp_max_r),
		.txack(txack),
		.out_busy(txd_vld),
		.pop_l1a(pop_l1a),
		.pop_evt(pop_evt),
		.pos(pos),
		.phase_sel(phase_sel),
		.clr_crc(clr_crc),
		.adv(adv),
		.last(last)
	);

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			samp_max_r <= '0;
			warn_r <= 1'b0;
			pop_l1a_d <= 1'b0;
		end else begin
			if (clr_crc) begin   // frame start
				samp_max_r <= samp_max;
				warn_r <= warn;
			end
			pop_l1a_d <= pop_l1a;
		end
	end

	// record is gone from the head after the header, keep what the trailer needs
	always_ff @(posedge RCLK) begin
		if (pop_l1a) begin
			num_r <= hdr_num;
			phase_r <= l1a_rd.dout[frame_pkg::L1A_PHASE];
		end
		if (pop_l1a_d)
			occ_r <= l1a_rd.count[frame_pkg::OCC_W-1:0];
	end

	assign hdr_num = l1a_rd.dout[frame_pkg::L1A_NUM_W-1:0];
	assign samp = ev_rd.dout[frame_pkg::SAMP_W-1:0];

	always_ff @(posedge RCLK) begin
		if (clr_crc)
			crc_r <= '0;
		else if (pop_evt)
			crc_r <= frame_pkg::crc15_d13({1'b0, samp}, crc_r);
	end

	always_comb begin
		serial = 1'b0;
		if ((32'(pos) - frame_pkg::PHASE_FIRST) <=
			(frame_pkg::PHASE_LAST - frame_pkg::PHASE_FIRST))
			serial = phase_r;
		else if ((32'(pos) - frame_pkg::MODE_FIRST) <=
			(frame_pkg::MODE_LAST - frame_pkg::MODE_FIRST))
			serial = (samp_max_r == frame_pkg::MODE_SAMP_MAX);   // 16 samples per frame
	end

	always_comb begin
		case (phase_sel)
			frame_pkg::SEL_HEAD: begin
				if (pos[0])
					word = {{(frame_pkg::TXD_W-frame_pkg::SAMP_W){1'b0}},
						hdr_num[frame_pkg::SAMP_W-1:0]};
				else
					word = {{(frame_pkg::TXD_W-frame_pkg::SAMP_W){1'b0}},
						hdr_num[frame_pkg::L1A_NUM_W-1 -: frame_pkg::SAMP_W]};
			end
			// bit 14 is the inverted overlap flag, never set here
			frame_pkg::SEL_SAMP: word = {1'b0, 1'b1, serial, 1'b0, samp};
			default: begin
				if (last)
					word = frame_pkg::TRL_END;
				else if (pos[1:0] == 2'd0)
					word = {1'b0, crc_r};
				else if (pos[1:0] == 2'd1)
					word = frame_pkg::TRL_ID;
				else
					word = {4'h7, num_r[5:0], occ_r, warn_r};
			end
		endcase
	end

	// assembly and output stage advance together, a stall holds both
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			asm_vld <= 1'b0;
			txd_vld <= 1'b0;
		end else if (out_ready) begin
			asm_vld <= adv;
			txd_vld <= asm_vld;
		end
	end

	always_ff @(posedge RCLK) begin
		if (adv)
			asm_word <= word;
		if (out_ready)
			txd <= asm_word;
	end

endmodule

// ==== hw/frame_seq_fsm.sv ====
`timescale 1ns/10ps

module frame_seq_fsm (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic go,
	input logic [frame_pkg::SMAX_W-1:0] samp_max_r,
	input logic txack,
	input logic out_busy,
	output logic pop_l1a,
	output logic pop_evt,
	output logic [frame_pkg::POS_W-1:0] pos,
	output logic [1:0] phase_sel,
	output logic clr_crc,
	output logic adv,
	output logic last
);
	logic [1:0] state;
	logic ready;
	logic phase_end;
	logic [frame_pkg::POS_W-1:0] samp_last;

	// pipeline moves only when the output word is free or taken
	assign ready = ~out_busy | txack;
	assign adv = (state != frame_pkg::SEQ_IDLE) & ready;

	// start also waits for ready so the idle slot reaches txd_vld
	assign clr_crc = (state == frame_pkg::SEQ_IDLE) & go & ready;

	assign phase_sel = state;
	assign samp_last = {{(frame_pkg::POS_W-frame_pkg::SMAX_W){1'b0}}, samp_max_r};

	always_comb begin
		case (state)
			frame_pkg::SEL_HEAD: phase_end = (pos == frame_pkg::HDR_WORDS - 1'b1);
			frame_pkg::SEL_SAMP: phase_end = (pos == samp_last);
			frame_pkg::SEL_TRL: phase_end = (pos == frame_pkg::TRL_WORDS - 1'b1);
			default: phase_end = 1'b0;
		endcase
	end

	assign pop_l1a = adv & (state == frame_pkg::SEL_HEAD) & phase_end;
	assign pop_evt = adv & (state == frame_pkg::SEL_SAMP);   // one sample per word
	assign last = (state == frame_pkg::SEL_TRL) & phase_end;

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= frame_pkg::SEQ_IDLE;
			pos <= '0;
		end else if (clr_crc) begin
			state <= frame_pkg::SEL_HEAD;
			pos <= '0;
		end else if (adv) begin
			if (phase_end) begin
				pos <= '0;
				case (state)
					frame_pkg::SEL_HEAD: state <= frame_pkg::SEL_SAMP;
					frame_pkg::SEL_SAMP: state <= frame_pkg::SEL_TRL;
					default: state <= frame_pkg::SEQ_IDLE;
				endcase
			end else begin
				pos <= pos + 1'b1;
			end
		end
	end

endmodule

// ==== hw/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter int W = 16,
	parameter int DEPTH_LOG2 = 4
) (
	input logic RCLK,
	input logic RST_RESYNC,
	input logic flush,
	input logic [W-1:0] din,
	input logic wr,
	buf_rd_if.buffer rd_port,
	output logic overflow
);
	logic [W-1:0] mem [0:(1<<DEPTH_LOG2)-1];
	logic [DEPTH_LOG2-1:0] wp;
	logic [DEPTH_LOG2-1:0] rp;
	logic [DEPTH_LOG2:0] cnt;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = cnt[DEPTH_LOG2];   // count can only reach 2**DEPTH_LOG2
	assign do_wr = wr & ~full;
	assign do_rd = rd_port.rd & ~rd_port.empty;

	assign rd_port.dout = mem[rp];
	assign rd_port.empty = (cnt == '0);
	assign rd_port.count = cnt;

	always_ff @(posedge RCLK) begin
		if (do_wr)
			mem[wp] <= din;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= wr & full;   // dropped write
			if (flush) begin
				wp <= '0;
				rp <= '0;
				cnt <= '0;
			end else begin
				if (do_wr)
					wp <= wp + 1'b1;
				if (do_rd)
					rp <= rp + 1'b1;
				case ({do_wr, do_rd})
					2'b10: cnt <= cnt + 1'b1;
					2'b01: cnt <= cnt - 1'b1;
					default: cnt <= cnt;
				endcase
			end
		end
	end

endmodule

// ==== hw/buf_rd_if.sv ====
`timescale 1ns/10ps

// show-ahead read side, dout valid whenever empty is low
interface buf_rd_if #(
	parameter int W = 16,
	parameter int DEPTH_LOG2 = 4
);
	logic rd;
	logic [W-1:0] dout;
	logic empty;
	logic [DEPTH_LOG2:0] count;

	modport buffer (
		input rd,
		output dout,
		output empty,
		output count
	);

	modport reader (
		output rd,
		input dout,
		input empty,
		input count
	);
endinterface

// ==== hw/csr_pkg.sv ====
package csr_pkg;

	localparam int WB_DW = 32;
	localparam int WB_AW = 4;

	localparam logic [WB_AW-1:0] ADDR_CTRL = 4'd0;
	localparam logic [WB_AW-1:0] ADDR_STAT = 4'd1;

	// control register
	localparam int CTRL_SMAX_LSB = 0;
	localparam int CTRL_SMAX_W = 7;
	localparam int CTRL_WARN = 8;
	localparam int CTRL_EN = 16;

	// status register, overflow bits are write-1-to-clear
	localparam int STAT_L1A_LSB = 0;
	localparam int STAT_L1A_W = 6;
	localparam int STAT_EVT_LSB = 8;
	localparam int STAT_EVT_W = 9;
	localparam int STAT_EVT_OVF = 24;
	localparam int STAT_L1A_OVF = 25;

endpackage

// ==== hw/frame_pkg.sv ====
package frame_pkg;

	localparam int SAMP_W = 12;
	localparam int EVT_W = 18;   // movlp, ovrlp, ocnt[3:0], data[11:0]
	localparam int L1A_W = 37;   // phase, match count[11:0], number[23:0]
	localparam int TXD_W = 16;
	localparam int EVT_DEPTH_LOG2 = 8;
	localparam int L1A_DEPTH_LOG2 = 5;

	localparam int L1A_NUM_W = 24;
	localparam int L1A_PHASE = 36;
	localparam int SMAX_W = 7;
	localparam int POS_W = 8;
	localparam int CRC_W = 15;
	localparam int OCC_W = 5;    // occupancy field in the status trailer

	localparam logic [TXD_W-1:0] TRL_ID = 16'h700C;
	localparam logic [TXD_W-1:0] TRL_END = 16'h7FFF;

	// serial bit windows, sample index within the frame
	localparam int unsigned PHASE_FIRST = 0;
	localparam int unsigned PHASE_LAST = 5;
	localparam int unsigned MODE_FIRST = 6;
	localparam int unsigned MODE_LAST = 11;
	localparam logic [SMAX_W-1:0] MODE_SAMP_MAX = 7'd15;

	localparam logic [POS_W-1:0] HDR_WORDS = 8'd2;
	localparam logic [POS_W-1:0] TRL_WORDS = 8'd4;

	// sequencer phase codes, idle shares the same field
	localparam logic [1:0] SEL_HEAD = 2'd0;
	localparam logic [1:0] SEL_SAMP = 2'd1;
	localparam logic [1:0] SEL_TRL = 2'd2;
	localparam logic [1:0] SEQ_IDLE = 2'd3;

	function automatic logic [CRC_W-1:0] crc15_d13(input logic [12:0] d,
		input logic [CRC_W-1:0] c);
		logic [CRC_W-1:0] n;
		n[0] = d[0] ^ c[2];
		n[1] = d[0] ^ d[1] ^ c[2] ^ c[3];
		n[2] = d[1] ^ d[2] ^ c[3] ^ c[4];
		n[3] = d[2] ^ d[3] ^ c[4] ^ c[5];
		n[4] = d[3] ^ d[4] ^ c[5] ^ c[6];
		n[5] = d[4] ^ d[5] ^ c[6] ^ c[7];
		n[6] = d[5] ^ d[6] ^ c[7] ^ c[8];
		n[7] = d[6] ^ d[7] ^ c[8] ^ c[9];
		n[8] = d[7] ^ d[8] ^ c[9] ^ c[10];
		n[9] = d[8] ^ d[9] ^ c[10] ^ c[11];
		n[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage
